//--- verilog/cap_pkg.sv
// Shared widths, root capability, opcode and fault encodings and bus structs, imported by every RTL block
package cap_pkg;

  localparam int unsigned NumRegs  = 16;
  localparam int unsigned RegAddrW = 4;
  localparam int unsigned PermW    = 3;

  // Bit positions inside the permission field
  localparam int unsigned PermRead   = 0;
  localparam int unsigned PermWrite  = 1;
  localparam int unsigned PermGlobal = 2;

  typedef struct packed {
    logic             tag;
    logic [PermW-1:0] perms;
    logic [31:0]      base;
    logic [31:0]      top;   // exclusive
  } cap_meta_t;

  typedef struct packed {
    logic [31:0] addr;
    cap_meta_t   meta;
  } reg_cap_t;

  // Register 1 after reset, covers the whole address space
  localparam reg_cap_t RootCap = '{
    addr: 32'h0,
    meta: '{
      tag:   1'b1,
      perms: PermW'((1 << PermRead) | (1 << PermWrite) | (1 << PermGlobal)),
      base:  32'h0,
      top:   32'hFFFF_FFFF
    }
  };

  localparam reg_cap_t NullCap = '0;

  typedef enum logic [3:0] {
    OP_CMOVE,
    OP_CSETADDR,
    OP_CINCADDR,
    OP_CSETBOUNDS,
    OP_CANDPERM,
    OP_CCLRTAG,
    OP_CLW,
    OP_CSW
  } cap_op_e;

  typedef enum logic [2:0] {
    FAULT_NONE,
    FAULT_TAG,
    FAULT_PERM,
    FAULT_BOUNDS,
    FAULT_ALIGN,
    FAULT_BUS
  } cap_fault_e;

  typedef struct packed {
    cap_op_e             op;
    logic [RegAddrW-1:0] rd;
    logic [RegAddrW-1:0] rs1;
    logic [RegAddrW-1:0] rs2;
    logic [31:0]         imm;
  } cap_cmd_t;

  typedef struct packed {
    cap_fault_e fault;
    reg_cap_t   result;
  } cap_rsp_t;

  // Wishbone classic master side
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [31:0] adr;
    logic [31:0] dat;
    logic [3:0]  sel;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic        err;
    logic [31:0] dat;
  } wb_rsp_t;

  typedef struct packed {
    logic        we;
    reg_cap_t    cap;
    logic [31:0] offset;
    logic [31:0] wdata;
  } lsu_req_t;

endpackage

//--- verilog/cap_regfile.sv
// Tagged capability register file, two combinational read ports and one write port, instanced by cap_top
`timescale 1ns/100ps

module cap_regfile (
  input  logic                         clk_i,
  input  logic                         rst_ni,

  input  logic [cap_pkg::RegAddrW-1:0] raddr_a_i,
  input  logic [cap_pkg::RegAddrW-1:0] raddr_b_i,
  output cap_pkg::reg_cap_t            rcap_a_o,
  output cap_pkg::reg_cap_t            rcap_b_o,

  input  logic [cap_pkg::RegAddrW-1:0] waddr_i,
  input  logic                         we_i,
  input  cap_pkg::reg_cap_t            wcap_i
);
  import cap_pkg::*;

  // Register 0 has no storage, it is hardwired to the null capability
  reg_cap_t rf_q [1:NumRegs-1];

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned i = 1; i < NumRegs; i++) begin
        rf_q[i] <= (i == 1) ? RootCap : NullCap;
      end
    end else if (we_i) begin
      for (int unsigned i = 1; i < NumRegs; i++) begin
        if (waddr_i == RegAddrW'(i)) begin
          rf_q[i] <= wcap_i;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Read ports
  //////////////////////////////////////////////////

  function automatic reg_cap_t read_port(logic [RegAddrW-1:0] addr);
    reg_cap_t cap;
    cap = NullCap;
    for (int unsigned i = 1; i < NumRegs; i++) begin
      if (addr == RegAddrW'(i)) begin
        cap = rf_q[i];
      end
    end
    return cap;
  endfunction

  always_comb begin
    rcap_a_o = read_port(raddr_a_i);
  end

  always_comb begin
    rcap_b_o = read_port(raddr_b_i);
  end

endmodule

//--- verilog/cap_access_check.sv
// Combinational capability check for one word access, reports the first broken rule to the LSU
`timescale 1ns/100ps

module cap_access_check (
  input  cap_pkg::reg_cap_t   cap_i,
  input  logic [31:0]         addr_i,
  input  logic                we_i,
  output cap_pkg::cap_fault_e fault_o
);
  import cap_pkg::*;

  logic [32:0] end_addr;
  logic        perm_ok;
  logic        below_base;
  logic        above_top;

  // One extra bit so that a wrap past 2^32 can never look in bounds
  assign end_addr = {1'b0, addr_i} + 33'd4;

  // Loads need Read, stores need Write
  assign perm_ok = we_i ? cap_i.meta.perms[PermWrite] : cap_i.meta.perms[PermRead];

  assign below_base = addr_i < cap_i.meta.base;
  assign above_top  = end_addr > {1'b0, cap_i.meta.top};

  // Priority: tag, permission, alignment, bounds
  always_comb begin
    if (!cap_i.meta.tag) begin
      fault_o = FAULT_TAG;
    end else if (!perm_ok) begin
      fault_o = FAULT_PERM;
    end else if (addr_i[1:0] != 2'b00) begin
      fault_o = FAULT_ALIGN;
    end else if (below_base || above_top) begin
      fault_o = FAULT_BOUNDS;
    end else begin
      fault_o = FAULT_NONE;
    end
  end

endmodule

//--- verilog/cap_lsu.sv
// Load/store unit, checks a word access and runs it as a single Wishbone classic cycle for cap_exec
`timescale 1ns/100ps

module cap_lsu (
  input  logic                clk_i,
  input  logic                rst_ni,

  input  logic                req_valid_i,
  input  cap_pkg::lsu_req_t   req_i,

  output logic                done_o,
  output cap_pkg::cap_fault_e fault_o,
  output logic [31:0]         rdata_o,

  output cap_pkg::wb_req_t    wb_req_o,
  input  cap_pkg::wb_rsp_t    wb_rsp_i
);
  import cap_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    BUS,
    DONE
  } lsu_state_e;

  lsu_state_e  state_q, state_d;
  logic [31:0] eff_addr;
  cap_fault_e  chk_fault;
  logic        bus_end;

  // Request and result held for the whole access
  logic        we_q;
  logic [31:0] adr_q;
  logic [31:0] dat_q;
  logic [31:0] rdata_q;
  cap_fault_e  fault_q;

  assign eff_addr = req_i.cap.addr + req_i.offset;
  assign bus_end  = wb_rsp_i.ack | wb_rsp_i.err;

  cap_access_check u_check (
    .cap_i   (req_i.cap),
    .addr_i  (eff_addr),
    .we_i    (req_i.we),
    .fault_o (chk_fault)
  );

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (req_valid_i) begin
          // Failed check skips the bus entirely
          state_d = (chk_fault == FAULT_NONE) ? BUS : DONE;
        end
      end
      BUS: begin
        if (bus_end) begin
          state_d = DONE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && req_valid_i) begin
      we_q    <= req_i.we;
      adr_q   <= eff_addr;
      dat_q   <= req_i.wdata;
      fault_q <= chk_fault;
    end else if (state_q == BUS && bus_end) begin
      // Stores hand back the written word
      rdata_q <= we_q ? dat_q : wb_rsp_i.dat;
      fault_q <= wb_rsp_i.err ? FAULT_BUS : FAULT_NONE;
    end
  end

  assign wb_req_o.cyc = (state_q == BUS);
  assign wb_req_o.stb = (state_q == BUS);
  assign wb_req_o.we  = we_q;
  assign wb_req_o.adr = adr_q;
  assign wb_req_o.dat = dat_q;
  assign wb_req_o.sel = 4'hF;

  assign done_o  = (state_q == DONE);
  assign fault_o = fault_q;
  assign rdata_o = rdata_q;

endmodule

//--- verilog/cap_exec.sv
// Command executor, accepts one capability command at a time and answers it on the response port
`timescale 1ns/100ps

module cap_exec (
  input  logic                         clk_i,
  input  logic                         rst_ni,

  input  logic                         cmd_valid_i,
  input  cap_pkg::cap_cmd_t            cmd_i,
  output logic                         cmd_ready_o,
  output logic                         rsp_valid_o,
  output cap_pkg::cap_rsp_t            rsp_o,

  output logic [cap_pkg::RegAddrW-1:0] rf_raddr_a_o,
  output logic [cap_pkg::RegAddrW-1:0] rf_raddr_b_o,
  input  cap_pkg::reg_cap_t            rf_rcap_a_i,
  input  cap_pkg::reg_cap_t            rf_rcap_b_i,
  output logic [cap_pkg::RegAddrW-1:0] rf_waddr_o,
  output logic                         rf_we_o,
  output cap_pkg::reg_cap_t            rf_wcap_o,

  output logic                         lsu_req_valid_o,
  output cap_pkg::lsu_req_t            lsu_req_o,
  input  logic                         lsu_done_i,
  input  cap_pkg::cap_fault_e          lsu_fault_i,
  input  logic [31:0]                  lsu_rdata_i,

  output logic                         busy_o
);
  import cap_pkg::*;

  typedef enum logic {
    IDLE,
    MEM
  } exec_state_e;

  exec_state_e state_q, state_d;
  cap_cmd_t    cmd_q;
  logic        accept;
  logic        is_mem;
  logic [32:0] bnd_top;
  reg_cap_t    reg_res;
  cap_fault_e  reg_fault;
  logic        rsp_valid_q;
  cap_rsp_t    rsp_q;
  cap_rsp_t    mem_rsp;

  assign accept  = cmd_valid_i & cmd_ready_o;
  assign is_mem  = (cmd_i.op == OP_CLW) || (cmd_i.op == OP_CSW);
  assign bnd_top = {1'b0, rf_rcap_a_i.addr} + {1'b0, cmd_i.imm};

  assign rf_raddr_a_o = cmd_i.rs1;
  assign rf_raddr_b_o = cmd_i.rs2;

  //////////////////////////////////////////////////
  // Register operations
  //////////////////////////////////////////////////

  always_comb begin
    reg_res   = rf_rcap_a_i;
    reg_fault = FAULT_NONE;
    case (cmd_i.op)
      OP_CSETADDR: reg_res.addr = cmd_i.imm;
      OP_CINCADDR: reg_res.addr = rf_rcap_a_i.addr + cmd_i.imm;
      OP_CSETBOUNDS: begin
        if (!rf_rcap_a_i.meta.tag) begin
          reg_fault = FAULT_TAG;
        end else if (bnd_top[32] || rf_rcap_a_i.addr < rf_rcap_a_i.meta.base ||
                     bnd_top[31:0] > rf_rcap_a_i.meta.top) begin
          // Only narrowing is allowed
          reg_fault = FAULT_BOUNDS;
        end else begin
          reg_res.meta.base = rf_rcap_a_i.addr;
          reg_res.meta.top  = bnd_top[31:0];
        end
      end
      OP_CANDPERM: reg_res.meta.perms = rf_rcap_a_i.meta.perms & cmd_i.imm[PermW-1:0];
      OP_CCLRTAG:  reg_res.meta.tag = 1'b0;
      default: ;
    endcase
    if (reg_fault != FAULT_NONE) begin
      reg_res = NullCap;
    end
  end

  //////////////////////////////////////////////////
  // Memory operations
  //////////////////////////////////////////////////

  assign lsu_req_valid_o  = accept & is_mem;
  assign lsu_req_o.we     = (cmd_i.op == OP_CSW);
  assign lsu_req_o.cap    = rf_rcap_a_i;
  assign lsu_req_o.offset = cmd_i.imm;
  assign lsu_req_o.wdata  = rf_rcap_b_i.addr;

  // Loaded or stored word as a plain untagged value
  always_comb begin
    mem_rsp.fault  = lsu_fault_i;
    mem_rsp.result = NullCap;
    if (lsu_fault_i == FAULT_NONE) begin
      mem_rsp.result.addr = lsu_rdata_i;
    end
  end

  // Writeback, load result while in MEM, else the register op result
  always_comb begin
    if (state_q == MEM) begin
      rf_we_o    = lsu_done_i && (cmd_q.op == OP_CLW) && (lsu_fault_i == FAULT_NONE);
      rf_waddr_o = cmd_q.rd;
      rf_wcap_o  = mem_rsp.result;
    end else begin
      rf_we_o    = accept && !is_mem && (reg_fault == FAULT_NONE);
      rf_waddr_o = cmd_i.rd;
      rf_wcap_o  = reg_res;
    end
  end

  always_comb begin
    state_d = state_q;
    if (state_q == IDLE && accept && is_mem) begin
      state_d = MEM;
    end else if (state_q == MEM && lsu_done_i) begin
      state_d = IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= IDLE;
      rsp_valid_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      rsp_valid_q <= accept & ~is_mem;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      cmd_q       <= cmd_i;
      rsp_q.fault  <= reg_fault;
      rsp_q.result <= reg_res;
    end
  end

  // Ready again once the response has gone out
  assign cmd_ready_o = (state_q == IDLE) & ~rsp_valid_q;
  assign rsp_valid_o = rsp_valid_q | ((state_q == MEM) & lsu_done_i);
  assign rsp_o       = (state_q == MEM) ? mem_rsp : rsp_q;
  assign busy_o      = (state_q != IDLE) | rsp_valid_q;

endmodule

//--- verilog/cap_top.sv
// Top level of the capability subsystem, wires executor, LSU and register file and drives the sleep flag
`timescale 1ns/100ps

module cap_top (
  input  logic               clk_i,
  input  logic               rst_ni,

  input  logic               cmd_valid_i,
  input  cap_pkg::cap_cmd_t  cmd_i,
  output logic               cmd_ready_o,

  output logic               rsp_valid_o,
  output cap_pkg::cap_rsp_t  rsp_o,

  output cap_pkg::wb_req_t   wb_req_o,
  input  cap_pkg::wb_rsp_t   wb_rsp_i,

  output logic               core_sleep_o
);
  import cap_pkg::*;

  logic                core_busy_d, core_busy_q;

  // Executor <-> register file
  logic [RegAddrW-1:0] rf_raddr_a;
  logic [RegAddrW-1:0] rf_raddr_b;
  logic [RegAddrW-1:0] rf_waddr;
  logic                rf_we;
  reg_cap_t            rf_rcap_a, rf_rcap_b;
  reg_cap_t            rf_wcap;

  // Executor <-> LSU
  logic                lsu_req_valid;
  lsu_req_t            lsu_req;
  logic                lsu_done;
  cap_fault_e          lsu_fault;
  logic [31:0]         lsu_rdata;

  //////////////////////////////////////////////////
  // Sleep indication
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      core_busy_q <= 1'b0;
    end else begin
      core_busy_q <= core_busy_d;
    end
  end

  // A pending command wakes the core in the same cycle
  assign core_sleep_o = ~core_busy_q & ~cmd_valid_i;

  //////////////////////////////////////////////////
  // Instances
  //////////////////////////////////////////////////

  cap_exec u_exec (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .cmd_valid_i     (cmd_valid_i),
    .cmd_i           (cmd_i),
    .cmd_ready_o     (cmd_ready_o),
    .rsp_valid_o     (rsp_valid_o),
    .rsp_o           (rsp_o),
    .rf_raddr_a_o    (rf_raddr_a),
    .rf_raddr_b_o    (rf_raddr_b),
    .rf_rcap_a_i     (rf_rcap_a),
    .rf_rcap_b_i     (rf_rcap_b),
    .rf_waddr_o      (rf_waddr),
    .rf_we_o         (rf_we),
    .rf_wcap_o       (rf_wcap),
    .lsu_req_valid_o (lsu_req_valid),
    .lsu_req_o       (lsu_req),
    .lsu_done_i      (lsu_done),
    .lsu_fault_i     (lsu_fault),
    .lsu_rdata_i     (lsu_rdata),
    .busy_o          (core_busy_d)
  );

  cap_lsu u_lsu (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (lsu_req_valid),
    .req_i       (lsu_req),
    .done_o      (lsu_done),
    .fault_o     (lsu_fault),
    .rdata_o     (lsu_rdata),
    .wb_req_o    (wb_req_o),
    .wb_rsp_i    (wb_rsp_i)
  );

  cap_regfile u_regfile (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (rf_raddr_a),
    .raddr_b_i (rf_raddr_b),
    .rcap_a_o  (rf_rcap_a),
    .rcap_b_o  (rf_rcap_b),
    .waddr_i   (rf_waddr),
    .we_i      (rf_we),
    .wcap_i    (rf_wcap)
  );

endmodule

//--- verif/tb_wb_mem.sv
// Wishbone classic slave memory for the testbench, random wait states and an error window
`timescale 1ns/100ps

module tb_wb_mem (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  cap_pkg::wb_req_t wb_req_i,
  output cap_pkg::wb_rsp_t wb_rsp_o
);
  import cap_pkg::*;

  logic [31:0] mem [logic [31:0]];
  logic        started_q;
  logic [1:0]  wait_q;

  // Unwritten words read back a pattern of their address
  function automatic logic [31:0] fill_word(logic [31:0] adr);
    return adr ^ 32'hC3A5_5A3C;
  endfunction

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wb_rsp_o  <= '0;
      started_q <= 1'b0;
      wait_q    <= '0;
    end else begin
      wb_rsp_o.ack <= 1'b0;
      wb_rsp_o.err <= 1'b0;
      if (wb_req_i.cyc && wb_req_i.stb && !wb_rsp_o.ack && !wb_rsp_o.err) begin
        if (!started_q) begin
          started_q <= 1'b1;
          wait_q    <= 2'($urandom_range(0, 3));
        end else if (wait_q != 0) begin
          wait_q <= wait_q - 2'd1;
        end else begin
          started_q <= 1'b0;
          // Error window
          if (wb_req_i.adr >= 32'h0000_F000 && wb_req_i.adr <= 32'h0000_FFFF) begin
            wb_rsp_o.err <= 1'b1;
          end else begin
            wb_rsp_o.ack <= 1'b1;
            if (wb_req_i.we) begin
              mem[wb_req_i.adr] = wb_req_i.dat;
            end else if (mem.exists(wb_req_i.adr)) begin
              wb_rsp_o.dat <= mem[wb_req_i.adr];
            end else begin
              wb_rsp_o.dat <= fill_word(wb_req_i.adr);
            end
          end
        end
      end
    end
  end

endmodule

//--- verif/tb_cap_top.sv
// Testbench for cap_top, drives commands, predicts responses with a shadow model, checks by assertions
`timescale 1ns/100ps

module tb_cap_top;
  import cap_pkg::*;

  localparam time         Period  = 100ns;
  localparam int unsigned NumCmds = 128;
  localparam int unsigned Seed    = 32'h03149019;

  logic     clk_i, rst_ni, cmd_valid_i, cmd_ready_o, rsp_valid_o, core_sleep_o;
  cap_cmd_t cmd_i;
  cap_rsp_t rsp_o, exp_rsp;
  wb_req_t  wb_req, exp_wb;
  wb_rsp_t  wb_rsp;
  logic     in_flight, fast_q, post_reset;
  logic     busy_q;
  int       errors;
  reg_cap_t    shadow [NumRegs];
  logic [31:0] mem_shadow [logic [31:0]];

  cap_top dut_i (
    .clk_i, .rst_ni, .cmd_valid_i, .cmd_i, .cmd_ready_o, .rsp_valid_o, .rsp_o,
    .wb_req_o (wb_req), .wb_rsp_i (wb_rsp), .core_sleep_o
  );

  tb_wb_mem u_mem (.clk_i, .rst_ni, .wb_req_i (wb_req), .wb_rsp_o (wb_rsp));

  initial begin
    clk_i = 1'b0;
    forever #(Period / 2) clk_i = ~clk_i;
  end

  // One command in flight from acceptance until its response
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) in_flight <= 1'b0;
    else if (cmd_valid_i && cmd_ready_o) in_flight <= 1'b1;
    else if (rsp_valid_o) in_flight <= 1'b0;
  end

  // Busy flag one cycle late, as the sleep output sees it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else begin
      busy_q <= in_flight;
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  assert property (@(posedge clk_i) disable iff (!rst_ni) rsp_valid_o |-> rsp_o == exp_rsp)
    else begin
      errors++;
      $display("error %0t rsp_o expected %h actual %h", $time, $sampled(exp_rsp),
               $sampled(rsp_o));
    end
  assert property (@(posedge clk_i) disable iff (!rst_ni) rsp_valid_o |-> in_flight)
    else begin
      errors++;
      $display("Response pulse at %0t without an accepted command", $time);
    end
  assert property (@(posedge clk_i) disable iff (!rst_ni) in_flight |-> !cmd_ready_o)
    else begin
      errors++;
      $display("error %0t cmd_ready_o expected 0 actual 1", $time);
    end
  // Register ops and failed checks answer in one cycle
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   cmd_valid_i && cmd_ready_o |=> !fast_q || rsp_valid_o)
    else begin
      errors++;
      $display("error %0t rsp_valid_o expected 1 actual 0", $time);
    end
  assert property (@(posedge clk_i) disable iff (!rst_ni) in_flight && fast_q |-> !wb_req.cyc)
    else begin
      errors++;
      $display("error %0t wb cyc expected 0 actual 1", $time);
    end
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   wb_req.stb && !wb_rsp.ack && !wb_rsp.err |=> wb_req.stb && $stable(wb_req))
    else begin
      errors++;
      $display("Wishbone request changed at %0t before ack or err", $time);
    end
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   wb_req.cyc && (wb_rsp.ack || wb_rsp.err) |=> !wb_req.cyc)
    else begin
      errors++;
      $display("error %0t wb cyc expected 0 actual 1", $time);
    end
  // Address, direction, byte enables and store data of every bus cycle
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   wb_req.stb |-> wb_req.we == exp_wb.we && wb_req.adr == exp_wb.adr &&
                                  wb_req.sel == exp_wb.sel &&
                                  (!wb_req.we || wb_req.dat == exp_wb.dat))
    else begin
      errors++;
      $display("error %0t wb_req_o expected %h actual %h", $time, $sampled(exp_wb),
               $sampled(wb_req));
    end
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   core_sleep_o == (!busy_q && !cmd_valid_i))
    else begin
      errors++;
      $display("error %0t core_sleep_o expected %b actual %b", $time,
               $sampled(!busy_q && !cmd_valid_i), $sampled(core_sleep_o));
    end
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   post_reset |-> cmd_ready_o && !rsp_valid_o && !wb_req.cyc && core_sleep_o)
    else begin
      errors++;
      $display("Idle state after reset is wrong at %0t", $time);
    end

  //////////////////////////////////////////////////
  // Shadow model
  //////////////////////////////////////////////////

  task automatic predict(input cap_cmd_t c, output cap_rsp_t r, output logic fast,
                         output wb_req_t wb);
    reg_cap_t    src, res;
    cap_fault_e  f;
    logic [32:0] sum;
    logic [31:0] ea;
    src  = shadow[c.rs1];
    res  = src;
    f    = FAULT_NONE;
    fast = 1'b1;
    wb   = '0;
    sum  = {1'b0, src.addr} + {1'b0, c.imm};
    ea   = src.addr + c.imm;
    case (c.op)
      OP_CSETADDR: res.addr = c.imm;
      OP_CINCADDR: res.addr = ea;
      OP_CANDPERM: res.meta.perms = src.meta.perms & c.imm[PermW-1:0];
      OP_CCLRTAG:  res.meta.tag = 1'b0;
      OP_CSETBOUNDS: begin
        if (!src.meta.tag) f = FAULT_TAG;
        else if (src.addr < src.meta.base || sum > {1'b0, src.meta.top}) f = FAULT_BOUNDS;
        else begin
          res.meta.base = src.addr;
          res.meta.top  = sum[31:0];
        end
      end
      OP_CLW, OP_CSW: begin
        res = NullCap;
        if (!src.meta.tag) f = FAULT_TAG;
        else if (!src.meta.perms[c.op == OP_CSW ? PermWrite : PermRead]) f = FAULT_PERM;
        else if (ea[1:0] != 2'b00) f = FAULT_ALIGN;
        else if (ea < src.meta.base || {1'b0, ea} + 33'd4 > {1'b0, src.meta.top}) begin
          f = FAULT_BOUNDS;
        end else begin
          fast   = 1'b0;
          wb.cyc = 1'b1;
          wb.stb = 1'b1;
          wb.we  = (c.op == OP_CSW);
          wb.adr = ea;
          wb.dat = shadow[c.rs2].addr;
          wb.sel = 4'hF;
          if (ea >= 32'h0000_F000 && ea <= 32'h0000_FFFF) f = FAULT_BUS;
          else if (c.op == OP_CSW) begin
            mem_shadow[ea] = shadow[c.rs2].addr;
            res.addr       = shadow[c.rs2].addr;
          end else begin
            res.addr = mem_shadow.exists(ea) ? mem_shadow[ea] : (ea ^ 32'hC3A5_5A3C);
          end
        end
      end
      default: ;
    endcase
    if (f != FAULT_NONE) res = NullCap;
    else if (c.op != OP_CSW && c.rd != 0) shadow[c.rd] = res;
    r.fault  = f;
    r.result = res;
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  function automatic cap_cmd_t make_cmd(cap_op_e op, int rd, int rs1, int rs2, logic [31:0] imm);
    cap_cmd_t c;
    c.op  = op;
    c.rd  = RegAddrW'(rd);
    c.rs1 = RegAddrW'(rs1);
    c.rs2 = RegAddrW'(rs2);
    c.imm = imm;
    return c;
  endfunction

  // Offer a command and return at the edge that accepts it
  task automatic send(cap_cmd_t c);
    cap_rsp_t r;
    logic     f;
    wb_req_t  w;
    cmd_valid_i <= 1'b1;
    cmd_i       <= c;
    do @(posedge clk_i); while (!cmd_ready_o);
    predict(c, r, f, w);
    exp_rsp <= r;
    fast_q  <= f;
    exp_wb  <= w;
  endtask

  task automatic wait_rsp();
    cmd_valid_i <= 1'b0;
    do @(posedge clk_i); while (!rsp_valid_o);
  endtask

  task automatic run(cap_cmd_t c);
    send(c);
    wait_rsp();
  endtask

  initial begin
    #((NumCmds * 10 + 20) * Period);
    $display("Timeout, the commands did not finish in time");
    $display("Test failed");
    $finish;
  end

  initial begin
    logic [31:0] off;
    void'($urandom(Seed));
    errors = 0;
    rst_ni = 1'b0;
    cmd_valid_i = 1'b0;
    cmd_i = '0;
    exp_rsp = '0;
    exp_wb = '0;
    fast_q = 1'b0;
    post_reset = 1'b0;
    foreach (shadow[i]) shadow[i] = NullCap;
    shadow[1] = RootCap;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    post_reset <= 1'b1;
    repeat (2) @(posedge clk_i);
    post_reset <= 1'b0;
    run(make_cmd(OP_CMOVE, 2, 1, 0, 0));
    // Derive a narrowed region and its variants
    run(make_cmd(OP_CSETADDR, 2, 1, 0, 32'h1000));
    run(make_cmd(OP_CSETBOUNDS, 3, 2, 0, 32'h100));
    run(make_cmd(OP_CANDPERM, 4, 3, 0, 32'h3));
    run(make_cmd(OP_CINCADDR, 5, 4, 0, 32'h10));
    run(make_cmd(OP_CCLRTAG, 6, 5, 0, 0));
    run(make_cmd(OP_CSETBOUNDS, 7, 6, 0, 32'h4));
    run(make_cmd(OP_CSETADDR, 7, 3, 0, 32'hF00));
    run(make_cmd(OP_CSETBOUNDS, 8, 7, 0, 32'h10));
    // Top beyond the old top
    run(make_cmd(OP_CSETBOUNDS, 8, 3, 0, 32'h200));
    run(make_cmd(OP_CSETADDR, 9, 1, 0, 32'hFFFF_FFF0));
    run(make_cmd(OP_CSETBOUNDS, 9, 9, 0, 32'h20));
    run(make_cmd(OP_CMOVE, 10, 9, 0, 0));
    run(make_cmd(OP_CMOVE, 0, 1, 0, 0));
    run(make_cmd(OP_CMOVE, 11, 0, 0, 0));
    // Store then load through the narrowed capability
    repeat (20) begin
      off = $urandom_range(0, 63) * 4;
      run(make_cmd(OP_CSETADDR, 12, 1, 0, $urandom));
      run(make_cmd(OP_CSW, 0, 4, 12, off));
      run(make_cmd(OP_CLW, 13, 4, 0, off));
    end
    // Check order: tag, permission, alignment, bounds
    run(make_cmd(OP_CLW, 13, 6, 0, 0));
    run(make_cmd(OP_CSW, 0, 11, 12, 32'h2));
    run(make_cmd(OP_CANDPERM, 7, 4, 0, 32'h1));
    run(make_cmd(OP_CSW, 0, 7, 12, 32'h2));
    run(make_cmd(OP_CANDPERM, 8, 4, 0, 32'h2));
    run(make_cmd(OP_CLW, 13, 8, 0, 32'h102));
    run(make_cmd(OP_CLW, 13, 4, 0, 32'h102));
    run(make_cmd(OP_CLW, 13, 4, 0, 32'h100));
    run(make_cmd(OP_CSW, 0, 4, 12, 32'hFFFF_FFFC));
    // Bus error window
    run(make_cmd(OP_CSETADDR, 15, 1, 0, 32'hF000));
    run(make_cmd(OP_CLW, 13, 15, 0, 32'h10));
    run(make_cmd(OP_CSW, 0, 15, 12, 32'h20));
    run(make_cmd(OP_CMOVE, 14, 13, 0, 0));
    // Back to back with valid held
    repeat (40) begin
      send(make_cmd(cap_op_e'($urandom_range(0, 7)), $urandom_range(2, 15),
                    $urandom_range(0, 15), $urandom_range(0, 15), $urandom_range(0, 255)));
    end
    wait_rsp();
    repeat (2) @(posedge clk_i);
    $display("Checks finished with %0d errors", errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- compile.f
verilog/cap_pkg.sv
verilog/cap_regfile.sv
verilog/cap_access_check.sv
verilog/cap_lsu.sv
verilog/cap_exec.sv
verilog/cap_top.sv
verif/tb_wb_mem.sv
verif/tb_cap_top.sv

//--- Bender.yml
package:
  name: cap_subsystem

sources:
  - verilog/cap_pkg.sv
  - verilog/cap_regfile.sv
  - verilog/cap_access_check.sv
  - verilog/cap_lsu.sv
  - verilog/cap_exec.sv
  - verilog/cap_top.sv
  - target: test
    files:
      - verif/tb_wb_mem.sv
      - verif/tb_cap_top.sv
